/* pit_counter.f */
rtl/pit_host_pkg.sv
rtl/pit_count_pkg.sv
rtl/pit_control_word.sv
rtl/pit_preset_access.sv
rtl/pit_count_engine.sv
rtl/pit_output_shaper.sv
rtl/pit_counter.sv
sim/pit_counter_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the pit_counter testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f pit_counter.f --top-module pit_counter_tb -o pit_counter_sim > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "Build failed with status $status"
    exit 1
fi

./obj_dir/pit_counter_sim > "$sim_log" 2>&1
status=$?
cat "$sim_log"

if grep -q "TEST FAILED" "$sim_log"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

/* sim/pit_counter_tb.sv */
module pit_counter_tb;

    import pit_host_pkg::*;
    import pit_count_pkg::*;

    // One row per scenario
    // out_edge is the rise edge in mode 0 and the pulse period in mode 2
    typedef struct packed {
        logic [7:0]  ctrl;
        logic [15:0] preset;
        logic [15:0] edges;
        logic [7:0]  gate_from;
        logic [7:0]  latch_at;
        logic [15:0] read_expect;
        logic [15:0] out_edge;
    } scenario_t;

    localparam int n_rows = 7;

    localparam scenario_t rows [n_rows] = '{
        '{8'h30, 16'h0006, 16'd9,   8'd0, 8'd0, 16'h0000, 16'd7},
        '{8'h30, 16'h0108, 16'd274, 8'd3, 8'd4, 16'h0106, 16'd265},
        '{8'h34, 16'h0004, 16'd13,  8'd0, 8'd6, 16'h0003, 16'd4},
        '{8'h31, 16'h0010, 16'd12,  8'd0, 8'd2, 16'h0009, 16'd11},
        '{8'h30, 16'h0010, 16'd18,  8'd0, 8'd2, 16'h000F, 16'd17},
        '{8'h20, 16'h0100, 16'd258, 8'd0, 8'd0, 16'h0000, 16'd257},
        '{8'h10, 16'h0007, 16'd9,   8'd0, 8'd0, 16'h0000, 16'd8}
    };

    logic      clock;
    logic      reset;
    pit_host_t host;
    logic      counter_clock;
    logic      counter_gate;
    pit_byte_t read_data;
    logic      counter_out;
    logic [7:0] lfsr_state = 8'd55;

    pit_counter i_pit_counter (
        .clock         (clock),
        .reset         (reset),
        .host          (host),
        .counter_clock (counter_clock),
        .counter_gate  (counter_gate),
        .read_data     (read_data),
        .counter_out   (counter_out)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Galois form with taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 8'hB8;
        end
        return state >> 1;
    endfunction

    // Gate hold of 1 to 8 counter clock edges
    task automatic draw_hold(output int hold);
        int value;
        value = 0;
        for (int i = 0; i < 3; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        hold = value + 1;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic int watchdog_cycles();
        int total;
        total = 0;
        for (int i = 0; i < n_rows; i++) begin
            total = total + int'(rows[i].edges) * 8 + 16;
        end
        return total + 200;
    endfunction

    function automatic logic expected_out(input scenario_t row, input int edge_index,
                                          input int hold);
        pit_ctrl_word_t word;
        int             shift;
        word  = pit_ctrl_word_t'(row.ctrl);
        shift = (row.gate_from != 0) ? hold : 0;
        if (word.mode == mode_2) begin
            return (edge_index % int'(row.out_edge)) != 0;
        end
        return edge_index >= int'(row.out_edge) + shift;
    endfunction

    task automatic host_write(input logic to_control, input logic [7:0] value);
        @(negedge clock);
        host.data          = value;
        host.write_control = to_control;
        host.write_counter = !to_control;
        @(negedge clock);
        host.write_control = 1'b0;
        host.write_counter = 1'b0;
    endtask

    task automatic load_scenario(input scenario_t row);
        pit_ctrl_word_t word;
        word = pit_ctrl_word_t'(row.ctrl);
        host_write(1'b1, row.ctrl);
        if (word.access != access_msb) begin
            host_write(1'b0, row.preset[7:0]);
        end
        if ((word.access == access_msb) || (word.access == access_lsb_msb)) begin
            host_write(1'b0, row.preset[15:8]);
        end
        @(negedge clock);
        // Idle level before the first counter clock edge
        check_value("counter_out", counter_out, word.mode == mode_2);
    endtask

    // One counter clock period of 4 clocks low and 4 high
    task automatic run_edge(input scenario_t row, input int edge_index, input int hold);
        logic       gate_low;
        logic       read_now;
        logic [7:0] expect_byte;
        gate_low = (row.gate_from != 0) && (edge_index > int'(row.gate_from))
                   && (edge_index <= int'(row.gate_from) + hold);
        read_now = (row.latch_at != 0) && ((edge_index == int'(row.latch_at) + 1)
                                           || (edge_index == int'(row.latch_at) + 2));
        @(negedge clock);
        counter_clock = 1'b0;
        counter_gate  = !gate_low;
        @(negedge clock);
        check_value("counter_out", counter_out, expected_out(row, edge_index, hold));
        if ((row.latch_at != 0) && (edge_index == int'(row.latch_at))) begin
            host.data          = 8'h00;
            host.write_control = 1'b1;
        end
        @(negedge clock);
        host.write_control = 1'b0;
        if (read_now) begin
            host.read_counter = 1'b1;
        end
        @(negedge clock);
        if (read_now) begin
            // Low byte first, then high byte
            expect_byte = (edge_index == int'(row.latch_at) + 1) ? row.read_expect[7:0]
                                                                 : row.read_expect[15:8];
            check_value("read_data", read_data, expect_byte);
            host.read_counter = 1'b0;
        end
        @(negedge clock);
        counter_clock = 1'b1;
        repeat (3) @(negedge clock);
    endtask

    initial begin
        int hold;
        host          = '0;
        counter_clock = 1'b1;
        counter_gate  = 1'b1;
        reset         = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_value("counter_out", counter_out, 1'b0);
        for (int r = 0; r < n_rows; r++) begin
            hold = 0;
            if (rows[r].gate_from != 0) begin
                draw_hold(hold);
            end
            load_scenario(rows[r]);
            for (int e = 1; e <= int'(rows[r].edges); e++) begin
                run_edge(rows[r], e, hold);
            end
        end
        $display("TEST PASSED");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles()) @(posedge clock);
        $display("Timeout: the scenarios did not complete in the expected time");
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* rtl/pit_counter.sv */
module pit_counter (
    input  logic                    clock,
    input  logic                    reset,
    input  pit_host_pkg::pit_host_t host,
    input  logic                    counter_clock,
    input  logic                    counter_gate,
    output pit_host_pkg::pit_byte_t read_data,
    output logic                    counter_out
);

    import pit_count_pkg::*;

    pit_config_t            counter_config;
    logic                   config_update;
    logic                   latch_hold;
    logic                   read_done;
    logic                   write_step;
    logic [count_width-1:0] preset_load;
    logic [count_width-1:0] count_latched;
    logic                   count_event;
    logic                   at_zero;
    logic                   at_one;
    logic                   started;

    pit_control_word i_pit_control_word (
        .clock          (clock),
        .reset          (reset),
        .host           (host),
        .read_done      (read_done),
        .counter_config (counter_config),
        .config_update  (config_update),
        .latch_hold     (latch_hold)
    );

    pit_preset_access i_pit_preset_access (
        .clock          (clock),
        .reset          (reset),
        .host           (host),
        .counter_config (counter_config),
        .config_update  (config_update),
        .count_latched  (count_latched),
        .preset_load    (preset_load),
        .write_step     (write_step),
        .read_done      (read_done),
        .read_data      (read_data)
    );

    pit_count_engine i_pit_count_engine (
        .clock          (clock),
        .reset          (reset),
        .host_write     (host.write_counter),
        .counter_config (counter_config),
        .config_update  (config_update),
        .write_step     (write_step),
        .preset_load    (preset_load),
        .latch_hold     (latch_hold),
        .counter_clock  (counter_clock),
        .counter_gate   (counter_gate),
        .count_latched  (count_latched),
        .count_event    (count_event),
        .at_zero        (at_zero),
        .at_one         (at_one),
        .started        (started)
    );

    pit_output_shaper i_pit_output_shaper (
        .clock          (clock),
        .reset          (reset),
        .counter_config (counter_config),
        .started        (started),
        .count_event    (count_event),
        .at_zero        (at_zero),
        .at_one         (at_one),
        .counter_out    (counter_out)
    );

endmodule

/* rtl/pit_output_shaper.sv */
module pit_output_shaper (
    input  logic                       clock,
    input  logic                       reset,
    input  pit_count_pkg::pit_config_t counter_config,
    input  logic                       started,
    input  logic                       count_event,
    input  logic                       at_zero,
    input  logic                       at_one,
    output logic                       counter_out
);

    import pit_count_pkg::*;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            counter_out <= 1'b0;
        end else if (!started) begin
            // Idle level of the selected mode
            counter_out <= (counter_config.mode == mode_2);
        end else if (count_event) begin
            case (counter_config.mode)
                mode_0: begin
                    // Terminal count is sticky until the next start
                    counter_out <= counter_out || at_zero;
                end
                mode_2: begin
                    // Low for the one period where the count is 1
                    counter_out <= !at_one;
                end
                default: counter_out <= counter_out;
            endcase
        end
    end

endmodule

/* rtl/pit_count_engine.sv */
module pit_count_engine (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  host_write,
    input  pit_count_pkg::pit_config_t            counter_config,
    input  logic                                  config_update,
    input  logic                                  write_step,
    input  logic [pit_count_pkg::count_width-1:0] preset_load,
    input  logic                                  latch_hold,
    input  logic                                  counter_clock,
    input  logic                                  counter_gate,
    output logic [pit_count_pkg::count_width-1:0] count_latched,
    output logic                                  count_event,
    output logic                                  at_zero,
    output logic                                  at_one,
    output logic                                  started
);

    import pit_host_pkg::*;
    import pit_count_pkg::*;

    logic                   prev_counter_clock;
    logic                   count_edge;
    logic                   write_complete;
    logic                   load_pending;
    logic [count_width-1:0] count;
    logic [count_width-1:0] count_dec;
    logic [count_width-1:0] count_next;
    logic [count_width-1:0] count_d;

    // Zero stays at zero; the top bit stands for 65536
    function automatic logic [count_width-1:0] decrement(
        input logic [count_width-1:0] value,
        input logic                   bcd
    );
        logic [count_width-1:0] result;
        logic                   borrow;
        result = value;
        borrow = 1'b1;
        if (value == '0) begin
            result = '0;
        end else if (!bcd) begin
            result = value - 1'b1;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (borrow) begin
                    if (value[4*i +: 4] == 4'd0) begin
                        result[4*i +: 4] = bcd_digit_max;
                    end else begin
                        result[4*i +: 4] = value[4*i +: 4] - 4'd1;
                        borrow = 1'b0;
                    end
                end
            end
            // Borrowed out of all digits, so 10000 becomes 9999
            if (borrow) begin
                result[count_width-1] = 1'b0;
            end
        end
        return result;
    endfunction

    function automatic logic bcd_digits_valid(input logic [count_width-1:0] value);
        logic valid;
        valid = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (value[4*i +: 4] > bcd_digit_max) begin
                valid = 1'b0;
            end
        end
        return valid;
    endfunction

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            prev_counter_clock <= 1'b0;
        end else begin
            prev_counter_clock <= counter_clock;
        end
    end

    assign count_edge     = prev_counter_clock && !counter_clock;
    assign write_complete = host_write && ((counter_config.access != access_lsb_msb)
                                          || (write_step == byte_step_msb));

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            load_pending <= 1'b0;
        end else if (config_update) begin
            load_pending <= 1'b0;
        end else if (write_complete) begin
            load_pending <= 1'b1;
        end else if (count_edge) begin
            load_pending <= 1'b0;
        end
    end

    // Mode 0 halts on the first of two bytes, mode 2 keeps running
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            started <= 1'b0;
        end else if (config_update) begin
            started <= 1'b0;
        end else if (host_write) begin
            if (counter_config.mode == mode_0) begin
                started <= write_complete;
            end else begin
                started <= started || write_complete;
            end
        end
    end

    assign count_dec = decrement(count, counter_config.bcd);

    always_comb begin
        count_next = counter_gate ? count_dec : count;
        case (counter_config.mode)
            mode_0: begin
                if (load_pending) begin
                    count_next = preset_load;
                end
            end
            mode_2: begin
                // Also covers the first load, as count sits at zero
                if (count_next == '0) begin
                    count_next = preset_load;
                end
            end
            default: count_next = count;
        endcase
    end

    assign count_event = count_edge && started;
    assign at_zero     = (count_next == '0);
    assign at_one      = (count_next == count_width'(1));

    always_comb begin
        if (!started) begin
            count_d = '0;
        end else if (count_event) begin
            count_d = count_next;
        end else begin
            count_d = count;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            count         <= '0;
            count_latched <= '0;
        end else begin
            count <= count_d;
            if (!latch_hold) begin
                count_latched <= count_d;
            end
        end
    end

    bcd_count_digits: assert property (
        @(posedge clock) disable iff (reset)
        counter_config.bcd |-> bcd_digits_valid(count_d)
    );

endmodule

/* rtl/pit_preset_access.sv */
module pit_preset_access (
    input  logic                                   clock,
    input  logic                                   reset,
    input  pit_host_pkg::pit_host_t                host,
    input  pit_count_pkg::pit_config_t             counter_config,
    input  logic                                   config_update,
    input  logic [pit_count_pkg::count_width-1:0]  count_latched,
    output logic [pit_count_pkg::count_width-1:0]  preset_load,
    output logic                                   write_step,
    output logic                                   read_done,
    output pit_host_pkg::pit_byte_t                read_data
);

    import pit_host_pkg::*;
    import pit_count_pkg::*;

    pit_ctrl_word_t               new_word;
    logic [2*host_data_width-1:0] preset_raw;
    logic [2*host_data_width-1:0] preset_word;
    logic                         read_step;
    logic                         prev_read_counter;
    logic                         read_fall;

    // Byte step that a new access setting starts from
    function automatic logic first_step(input pit_access_e access);
        return (access == access_msb) ? byte_step_msb : byte_step_lsb;
    endfunction

    // Steps reset on the same strobe that updates the config
    assign new_word = pit_ctrl_word_t'(host.data);

    always_ff @(posedge clock) begin
        if (host.write_counter) begin
            if (write_step == byte_step_lsb) begin
                preset_raw[host_data_width-1:0] <= host.data;
            end else begin
                preset_raw[2*host_data_width-1:host_data_width] <= host.data;
            end
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            write_step <= byte_step_msb;
        end else if (config_update) begin
            write_step <= first_step(new_word.access);
        end else if (host.write_counter && (counter_config.access == access_lsb_msb)) begin
            write_step <= !write_step;
        end
    end

    // Single byte accesses zero the other byte
    always_comb begin
        case (counter_config.access)
            access_msb: preset_word = {preset_raw[15:8], 8'h00};
            access_lsb: preset_word = {8'h00, preset_raw[7:0]};
            default:    preset_word = preset_raw;
        endcase
    end

    assign preset_load = {preset_word == '0, preset_word};

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            prev_read_counter <= 1'b0;
        end else begin
            prev_read_counter <= host.read_counter;
        end
    end

    assign read_fall = prev_read_counter && !host.read_counter;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            read_step <= byte_step_msb;
        end else if (config_update) begin
            read_step <= first_step(new_word.access);
        end else if (read_fall && (counter_config.access == access_lsb_msb)) begin
            read_step <= !read_step;
        end
    end

    // Last byte of the sequence, msb in lsb_msb access
    assign read_done = read_fall && ((counter_config.access != access_lsb_msb)
                                     || (read_step == byte_step_msb));

    assign read_data = (read_step == byte_step_lsb) ? count_latched[7:0] : count_latched[15:8];

    host_strobes_exclusive: assert property (
        @(posedge clock) disable iff (reset)
        !(host.write_counter && host.write_control)
    );

endmodule

/* rtl/pit_control_word.sv */
module pit_control_word (
    input  logic                       clock,
    input  logic                       reset,
    input  pit_host_pkg::pit_host_t    host,
    input  logic                       read_done,
    output pit_count_pkg::pit_config_t counter_config,
    output logic                       config_update,
    output logic                       latch_hold
);

    import pit_count_pkg::*;

    pit_ctrl_word_t ctrl_word;
    logic           mode_supported;
    logic           latch_command;

    // Single channel, the select field is not decoded
    assign ctrl_word = pit_ctrl_word_t'(host.data);

    assign mode_supported = (ctrl_word.mode == mode_0) || (ctrl_word.mode == mode_2);
    assign latch_command  = host.write_control && (ctrl_word.access == access_latch);

    // Words selecting other modes are dropped entirely
    assign config_update = host.write_control && (ctrl_word.access != access_latch)
                           && mode_supported;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            counter_config <= '{access: access_msb, mode: mode_0, bcd: 1'b0};
        end else if (config_update) begin
            counter_config <= '{
                access: ctrl_word.access,
                mode:   ctrl_word.mode,
                bcd:    ctrl_word.bcd
            };
        end
    end

    // Freeze the read-back value until the last byte has gone out
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            latch_hold <= 1'b0;
        end else if (latch_command) begin
            latch_hold <= 1'b1;
        end else if (read_done) begin
            latch_hold <= 1'b0;
        end
    end

    config_mode_supported: assert property (
        @(posedge clock) disable iff (reset)
        counter_config.mode inside {mode_0, mode_2}
    );

endmodule

/* rtl/pit_count_pkg.sv */
package pit_count_pkg;

    // 16 count bits plus a flag bit for a zero preset (65536)
    localparam int count_width = 17;

    localparam logic [3:0] bcd_digit_max = 4'd9;

    // Control word bits 5:4
    typedef enum logic [1:0] {
        access_latch   = 2'b00,
        access_lsb     = 2'b01,
        access_msb     = 2'b10,
        access_lsb_msb = 2'b11
    } pit_access_e;

    // Control word bits 3:1
    typedef enum logic [2:0] {
        mode_0 = 3'b000,
        mode_1 = 3'b001,
        mode_2 = 3'b010,
        mode_3 = 3'b011,
        mode_4 = 3'b100,
        mode_5 = 3'b101
    } pit_mode_e;

    typedef struct packed {
        logic [1:0]  select;
        pit_access_e access;
        pit_mode_e   mode;
        logic        bcd;
    } pit_ctrl_word_t;

    // Stored per-channel configuration
    typedef struct packed {
        pit_access_e access;
        pit_mode_e   mode;
        logic        bcd;
    } pit_config_t;

endpackage

/* rtl/pit_host_pkg.sv */
package pit_host_pkg;

    localparam int host_data_width = 8;

    typedef logic [host_data_width-1:0] pit_byte_t;

    // Strobes from the host side of the timer
    typedef struct packed {
        pit_byte_t data;
        logic      write_control;
        logic      write_counter;
        logic      read_counter;
    } pit_host_t;

    // Byte step encoding shared by preset writes and count reads
    // In lsb_msb access the step starts at lsb and toggles per byte
    localparam logic byte_step_msb = 1'b0;
    localparam logic byte_step_lsb = 1'b1;

endpackage
